//--- src/ex_isa_pkg.sv
// opcode codes are private to this stage, so the decoder must map instructions onto them
package ex_isa_pkg;

    // datapath and instruction field widths
    localparam int data_w     = 32;
    localparam int reg_addr_w = 5;
    localparam int shamt_w    = 5;
    localparam int imm_w      = 16;
    localparam int hilo_w     = 64;

    // jal writes its return address here
    localparam logic [reg_addr_w-1:0] link_reg = 5'd31;

    // op_nop marks a cycle with no instruction
    typedef enum logic [7:0]
    {
        op_nop,
        // add and subtract, signed forms trap on overflow
        op_add, op_addu, op_sub, op_subu,
        op_addi, op_addiu,
        // set on less than
        op_slt, op_sltu, op_slti, op_sltiu,
        // logic
        op_and, op_andi, op_or, op_ori,
        op_xor, op_xori, op_nor, op_lui,
        // shifts, v forms take the amount from rs
        op_sll, op_sllv, op_srl, op_srlv,
        op_sra, op_srav,
        // leading bit counts
        op_clz, op_clo,
        // conditional moves
        op_movz, op_movn,
        // hi/lo transfers
        op_mfhi, op_mflo, op_mthi, op_mtlo,
        // link writes
        op_jal, op_jalr,
        // loads
        op_lb, op_lbu, op_lh, op_lhu,
        op_lw, op_lwl, op_lwr,
        // stores
        op_sb, op_sh, op_sw,
        op_swl, op_swr
    } ex_op_e;

endpackage

//--- src/ex_mem_pkg.sv
// memory access descriptor codes as seen by the mem stage; no cache or tlb attributes
package ex_mem_pkg;

    // direction of the data movement
    typedef enum logic [1:0]
    {
        // register to register, no memory access
        dir_r2r = 2'd0,
        // load
        dir_m2r = 2'd1,
        // store
        dir_r2m = 2'd2
    } mem_dir_e;

    // access width, left and right words are the unaligned lwl/lwr/swl/swr halves
    typedef enum logic [2:0]
    {
        size_byte       = 3'd0,
        size_half       = 3'd1,
        size_word       = 3'd2,
        size_left_word  = 3'd3,
        size_right_word = 3'd4
    } mem_size_e;

endpackage

//--- src/ex_alu.sv
// combinational, a dest of 0 means no register write; mult, div and cp0 work are not handled
`timescale 1ns/1ps

module ex_alu
(
    input  ex_isa_pkg::ex_op_e                op_i,
    input  logic [ex_isa_pkg::reg_addr_w-1:0] rs_i,
    input  logic [ex_isa_pkg::reg_addr_w-1:0] rt_i,
    input  logic [ex_isa_pkg::reg_addr_w-1:0] rd_i,
    input  logic [ex_isa_pkg::data_w-1:0]     rs_val_i,
    input  logic [ex_isa_pkg::data_w-1:0]     rt_val_i,
    input  logic [ex_isa_pkg::data_w-1:0]     return_addr_i,
    input  logic [ex_isa_pkg::imm_w-1:0]      imm_i,
    input  logic [ex_isa_pkg::shamt_w-1:0]    shamt_i,
    input  logic [ex_isa_pkg::hilo_w-1:0]     hilo_i,
    output logic [ex_isa_pkg::data_w-1:0]     result_o,
    output logic [ex_isa_pkg::reg_addr_w-1:0] dest_o,
    output logic                              ovf_o,
    output logic [ex_isa_pkg::hilo_w-1:0]     hilo_o,
    output logic                              hilo_we_o
);

    logic [ex_isa_pkg::data_w-1:0]  sext_imm;
    logic [ex_isa_pkg::data_w-1:0]  zext_imm;
    logic [ex_isa_pkg::data_w-1:0]  op_b;
    logic [ex_isa_pkg::data_w-1:0]  op_b_eff;
    logic [ex_isa_pkg::data_w-1:0]  sum;
    logic                           carry;
    logic                           sub_op;
    logic                           lt;
    logic [ex_isa_pkg::shamt_w-1:0] sh_amt;
    logic [ex_isa_pkg::data_w-1:0]  cnt_src;
    // 0 to 32
    logic [5:0]                     lead_cnt;

    assign sext_imm = {{(ex_isa_pkg::data_w - ex_isa_pkg::imm_w){imm_i[ex_isa_pkg::imm_w-1]}},
                       imm_i};
    assign zext_imm = {{(ex_isa_pkg::data_w - ex_isa_pkg::imm_w){1'b0}}, imm_i};

    // second operand, immediate forms take the sign-extended immediate
    assign op_b = (op_i inside {ex_isa_pkg::op_addi, ex_isa_pkg::op_addiu,
                                ex_isa_pkg::op_slti, ex_isa_pkg::op_sltiu}) ? sext_imm : rt_val_i;

    // compares subtract too, the carry out gives the unsigned result
    assign sub_op = op_i inside {ex_isa_pkg::op_sub, ex_isa_pkg::op_subu,
                                 ex_isa_pkg::op_slt, ex_isa_pkg::op_sltu,
                                 ex_isa_pkg::op_slti, ex_isa_pkg::op_sltiu};

    // two's complement negate as invert plus carry in
    assign op_b_eff = sub_op ? ~op_b : op_b;
    assign {carry, sum} = {1'b0, rs_val_i} + {1'b0, op_b_eff}
                        + {{ex_isa_pkg::data_w{1'b0}}, sub_op};

    // signed overflow only matters for the trapping forms
    assign ovf_o = (op_i inside {ex_isa_pkg::op_add, ex_isa_pkg::op_addi, ex_isa_pkg::op_sub})
                 && (rs_val_i[ex_isa_pkg::data_w-1] == op_b_eff[ex_isa_pkg::data_w-1])
                 && (sum[ex_isa_pkg::data_w-1] != rs_val_i[ex_isa_pkg::data_w-1]);

    // signs differ means a is less iff a is negative, else the difference sign decides
    assign lt = (op_i inside {ex_isa_pkg::op_slt, ex_isa_pkg::op_slti}) ?
                ((rs_val_i[ex_isa_pkg::data_w-1] != op_b[ex_isa_pkg::data_w-1]) ?
                 rs_val_i[ex_isa_pkg::data_w-1] : sum[ex_isa_pkg::data_w-1]) : ~carry;

    assign sh_amt = (op_i inside {ex_isa_pkg::op_sllv, ex_isa_pkg::op_srlv,
                                  ex_isa_pkg::op_srav}) ?
                    rs_val_i[ex_isa_pkg::shamt_w-1:0] : shamt_i;

    // clo counts the leading zeros of the inverted operand
    assign cnt_src = (op_i == ex_isa_pkg::op_clo) ? ~rs_val_i : rs_val_i;

    // highest set bit wins
    always_comb
    begin
        lead_cnt = 6'd32;
        for (int i = 0; i < ex_isa_pkg::data_w; i++)
        begin
            if (cnt_src[i])
            begin
                lead_cnt = 6'(ex_isa_pkg::data_w - 1 - i);
            end
        end
    end

    always_comb
    begin
        result_o  = '0;
        hilo_o    = hilo_i;
        hilo_we_o = 1'b0;
        case (op_i)
            ex_isa_pkg::op_add, ex_isa_pkg::op_addu, ex_isa_pkg::op_sub, ex_isa_pkg::op_subu,
            ex_isa_pkg::op_addi, ex_isa_pkg::op_addiu:
                result_o = sum;
            ex_isa_pkg::op_slt, ex_isa_pkg::op_sltu, ex_isa_pkg::op_slti, ex_isa_pkg::op_sltiu:
                result_o = {{(ex_isa_pkg::data_w - 1){1'b0}}, lt};
            ex_isa_pkg::op_and:  result_o = rs_val_i & rt_val_i;
            ex_isa_pkg::op_andi: result_o = rs_val_i & zext_imm;
            ex_isa_pkg::op_or:   result_o = rs_val_i | rt_val_i;
            ex_isa_pkg::op_ori:  result_o = rs_val_i | zext_imm;
            ex_isa_pkg::op_xor:  result_o = rs_val_i ^ rt_val_i;
            ex_isa_pkg::op_xori: result_o = rs_val_i ^ zext_imm;
            ex_isa_pkg::op_nor:  result_o = ~(rs_val_i | rt_val_i);
            ex_isa_pkg::op_lui:  result_o = {imm_i, {(ex_isa_pkg::data_w - ex_isa_pkg::imm_w){1'b0}}};
            ex_isa_pkg::op_sll, ex_isa_pkg::op_sllv:
                result_o = rt_val_i << sh_amt;
            ex_isa_pkg::op_srl, ex_isa_pkg::op_srlv:
                result_o = rt_val_i >> sh_amt;
            ex_isa_pkg::op_sra, ex_isa_pkg::op_srav:
                result_o = $signed(rt_val_i) >>> sh_amt;
            ex_isa_pkg::op_clz, ex_isa_pkg::op_clo:
                result_o = {{(ex_isa_pkg::data_w - 6){1'b0}}, lead_cnt};
            ex_isa_pkg::op_movz, ex_isa_pkg::op_movn:
                result_o = rs_val_i;
            ex_isa_pkg::op_mfhi: result_o = hilo_i[ex_isa_pkg::hilo_w-1:ex_isa_pkg::data_w];
            ex_isa_pkg::op_mflo: result_o = hilo_i[ex_isa_pkg::data_w-1:0];
            ex_isa_pkg::op_mthi:
            begin
                hilo_o    = {rs_val_i, hilo_i[ex_isa_pkg::data_w-1:0]};
                hilo_we_o = 1'b1;
            end
            ex_isa_pkg::op_mtlo:
            begin
                hilo_o    = {hilo_i[ex_isa_pkg::hilo_w-1:ex_isa_pkg::data_w], rs_val_i};
                hilo_we_o = 1'b1;
            end
            ex_isa_pkg::op_jal, ex_isa_pkg::op_jalr:
                result_o = return_addr_i;
            // store data, and the old rt value that lwl and lwr merge into
            ex_isa_pkg::op_lb, ex_isa_pkg::op_lbu, ex_isa_pkg::op_lh, ex_isa_pkg::op_lhu,
            ex_isa_pkg::op_lw, ex_isa_pkg::op_lwl, ex_isa_pkg::op_lwr,
            ex_isa_pkg::op_sb, ex_isa_pkg::op_sh, ex_isa_pkg::op_sw,
            ex_isa_pkg::op_swl, ex_isa_pkg::op_swr:
                result_o = rt_val_i;
            default:
                result_o = '0;
        endcase
    end

    // rs is a source in every format and never a destination
    always_comb
    begin
        case (op_i)
            ex_isa_pkg::op_add, ex_isa_pkg::op_addu, ex_isa_pkg::op_sub, ex_isa_pkg::op_subu,
            ex_isa_pkg::op_slt, ex_isa_pkg::op_sltu, ex_isa_pkg::op_and, ex_isa_pkg::op_or,
            ex_isa_pkg::op_xor, ex_isa_pkg::op_nor, ex_isa_pkg::op_sll, ex_isa_pkg::op_sllv,
            ex_isa_pkg::op_srl, ex_isa_pkg::op_srlv, ex_isa_pkg::op_sra, ex_isa_pkg::op_srav,
            ex_isa_pkg::op_clz, ex_isa_pkg::op_clo, ex_isa_pkg::op_mfhi, ex_isa_pkg::op_mflo,
            ex_isa_pkg::op_jalr:
                dest_o = rd_i;
            ex_isa_pkg::op_addi, ex_isa_pkg::op_addiu, ex_isa_pkg::op_slti, ex_isa_pkg::op_sltiu,
            ex_isa_pkg::op_andi, ex_isa_pkg::op_ori, ex_isa_pkg::op_xori, ex_isa_pkg::op_lui,
            ex_isa_pkg::op_lb, ex_isa_pkg::op_lbu, ex_isa_pkg::op_lh, ex_isa_pkg::op_lhu,
            ex_isa_pkg::op_lw, ex_isa_pkg::op_lwl, ex_isa_pkg::op_lwr:
                dest_o = rt_i;
            ex_isa_pkg::op_movz: dest_o = (rt_val_i == '0) ? rd_i : '0;
            ex_isa_pkg::op_movn: dest_o = (rt_val_i != '0) ? rd_i : '0;
            ex_isa_pkg::op_jal:  dest_o = ex_isa_pkg::link_reg;
            default:
                dest_o = '0;
        endcase
    end

endmodule

//--- src/ex_agu.sv
// address is formed for memory opcodes only, alignment and exceptions are left to the mem stage
`timescale 1ns/1ps

module ex_agu
(
    input  ex_isa_pkg::ex_op_e            op_i,
    input  logic [ex_isa_pkg::data_w-1:0] rs_val_i,
    input  logic [ex_isa_pkg::imm_w-1:0]  imm_i,
    output logic [ex_isa_pkg::data_w-1:0] addr_o,
    output ex_mem_pkg::mem_dir_e          dir_o,
    output ex_mem_pkg::mem_size_e         size_o,
    output logic                          signed_o
);

    logic [ex_isa_pkg::data_w-1:0] sext_imm;

    // own extension and adder, off the alu operand path
    assign sext_imm = {{(ex_isa_pkg::data_w - ex_isa_pkg::imm_w){imm_i[ex_isa_pkg::imm_w-1]}},
                       imm_i};

    always_comb
    begin
        case (op_i)
            ex_isa_pkg::op_lb, ex_isa_pkg::op_lbu, ex_isa_pkg::op_lh, ex_isa_pkg::op_lhu,
            ex_isa_pkg::op_lw, ex_isa_pkg::op_lwl, ex_isa_pkg::op_lwr:
                dir_o = ex_mem_pkg::dir_m2r;
            ex_isa_pkg::op_sb, ex_isa_pkg::op_sh, ex_isa_pkg::op_sw,
            ex_isa_pkg::op_swl, ex_isa_pkg::op_swr:
                dir_o = ex_mem_pkg::dir_r2m;
            default:
                dir_o = ex_mem_pkg::dir_r2r;
        endcase
    end

    // word also covers every non-memory opcode
    always_comb
    begin
        case (op_i)
            ex_isa_pkg::op_lb, ex_isa_pkg::op_lbu, ex_isa_pkg::op_sb:
                size_o = ex_mem_pkg::size_byte;
            ex_isa_pkg::op_lh, ex_isa_pkg::op_lhu, ex_isa_pkg::op_sh:
                size_o = ex_mem_pkg::size_half;
            ex_isa_pkg::op_lwl, ex_isa_pkg::op_swl:
                size_o = ex_mem_pkg::size_left_word;
            ex_isa_pkg::op_lwr, ex_isa_pkg::op_swr:
                size_o = ex_mem_pkg::size_right_word;
            default:
                size_o = ex_mem_pkg::size_word;
        endcase
    end

    // only the unsigned loads skip sign extension of the read data
    assign signed_o = !(op_i inside {ex_isa_pkg::op_lbu, ex_isa_pkg::op_lhu});

    assign addr_o = (dir_o == ex_mem_pkg::dir_r2r) ? '0 : rs_val_i + sext_imm;

endmodule

//--- src/ex_writeback.sv
// one cycle of latency, no stall input; an overflowing add or sub loses its writes
`timescale 1ns/1ps

module ex_writeback
(
    input  logic                              clk,
    input  logic                              rst_i,
    input  logic [ex_isa_pkg::data_w-1:0]     alu_result_i,
    input  logic [ex_isa_pkg::reg_addr_w-1:0] alu_dest_i,
    input  logic                              alu_ovf_i,
    input  logic [ex_isa_pkg::hilo_w-1:0]     alu_hilo_i,
    input  logic                              alu_hilo_we_i,
    input  logic [ex_isa_pkg::data_w-1:0]     agu_addr_i,
    input  ex_mem_pkg::mem_dir_e              agu_dir_i,
    input  ex_mem_pkg::mem_size_e             agu_size_i,
    input  logic                              agu_signed_i,
    output logic [ex_isa_pkg::data_w-1:0]     result_o,
    output logic [ex_isa_pkg::reg_addr_w-1:0] dest_o,
    output logic                              overflow_o,
    output logic [ex_isa_pkg::hilo_w-1:0]     hilo_o,
    output logic                              hilo_we_o,
    output logic [ex_isa_pkg::data_w-1:0]     mem_addr_o,
    output ex_mem_pkg::mem_dir_e              mem_dir_o,
    output ex_mem_pkg::mem_size_e             mem_size_o,
    output logic                              mem_signed_o
);

    // reset values match an idle nop
    always_ff @(posedge clk)
    begin
        if (rst_i)
        begin
            result_o     <= '0;
            dest_o       <= '0;
            overflow_o   <= 1'b0;
            hilo_we_o    <= 1'b0;
            mem_addr_o   <= '0;
            mem_dir_o    <= ex_mem_pkg::dir_r2r;
            mem_size_o   <= ex_mem_pkg::size_word;
            mem_signed_o <= 1'b1;
        end
        else
        begin
            // result still passes so the exception path can see it
            result_o     <= alu_result_i;
            dest_o       <= alu_ovf_i ? '0 : alu_dest_i;
            overflow_o   <= alu_ovf_i;
            hilo_we_o    <= alu_hilo_we_i && !alu_ovf_i;
            mem_addr_o   <= agu_addr_i;
            mem_dir_o    <= agu_dir_i;
            mem_size_o   <= agu_size_i;
            mem_signed_o <= agu_signed_i;
        end
    end

    // new hi/lo pair, qualified by hilo_we_o
    always_ff @(posedge clk)
    begin
        hilo_o <= alu_hilo_i;
    end

endmodule

//--- src/ex_stage.sv
// execute stage top, one instruction per clock with 1 cycle latency and no stall or handshake
`timescale 1ns/1ps

module ex_stage
(
    input  logic                              clk,
    input  logic                              rst_i,
    input  ex_isa_pkg::ex_op_e                op_i,
    input  logic [ex_isa_pkg::reg_addr_w-1:0] rs_i,
    input  logic [ex_isa_pkg::reg_addr_w-1:0] rt_i,
    input  logic [ex_isa_pkg::reg_addr_w-1:0] rd_i,
    input  logic [ex_isa_pkg::data_w-1:0]     rs_val_i,
    input  logic [ex_isa_pkg::data_w-1:0]     rt_val_i,
    input  logic [ex_isa_pkg::imm_w-1:0]      imm_i,
    input  logic [ex_isa_pkg::shamt_w-1:0]    shamt_i,
    input  logic [ex_isa_pkg::data_w-1:0]     return_addr_i,
    input  logic [ex_isa_pkg::hilo_w-1:0]     hilo_i,
    output logic [ex_isa_pkg::data_w-1:0]     result_o,
    output logic [ex_isa_pkg::reg_addr_w-1:0] dest_o,
    output logic                              overflow_o,
    output logic [ex_isa_pkg::hilo_w-1:0]     hilo_o,
    output logic                              hilo_we_o,
    output logic [ex_isa_pkg::data_w-1:0]     mem_addr_o,
    output ex_mem_pkg::mem_dir_e              mem_dir_o,
    output ex_mem_pkg::mem_size_e             mem_size_o,
    output logic                              mem_signed_o
);

    logic [ex_isa_pkg::data_w-1:0]     alu_result;
    logic [ex_isa_pkg::reg_addr_w-1:0] alu_dest;
    logic                              alu_ovf;
    logic [ex_isa_pkg::hilo_w-1:0]     alu_hilo;
    logic                              alu_hilo_we;
    logic [ex_isa_pkg::data_w-1:0]     agu_addr;
    ex_mem_pkg::mem_dir_e              agu_dir;
    ex_mem_pkg::mem_size_e             agu_size;
    logic                              agu_signed;

    // alu and agu decode the same opcode in parallel
    ex_alu u_alu
    (
        .op_i          (op_i),
        .rs_i          (rs_i),
        .rt_i          (rt_i),
        .rd_i          (rd_i),
        .rs_val_i      (rs_val_i),
        .rt_val_i      (rt_val_i),
        .return_addr_i (return_addr_i),
        .imm_i         (imm_i),
        .shamt_i       (shamt_i),
        .hilo_i        (hilo_i),
        .result_o      (alu_result),
        .dest_o        (alu_dest),
        .ovf_o         (alu_ovf),
        .hilo_o        (alu_hilo),
        .hilo_we_o     (alu_hilo_we)
    );

    ex_agu u_agu
    (
        .op_i     (op_i),
        .rs_val_i (rs_val_i),
        .imm_i    (imm_i),
        .addr_o   (agu_addr),
        .dir_o    (agu_dir),
        .size_o   (agu_size),
        .signed_o (agu_signed)
    );

    ex_writeback u_writeback
    (
        .clk           (clk),
        .rst_i         (rst_i),
        .alu_result_i  (alu_result),
        .alu_dest_i    (alu_dest),
        .alu_ovf_i     (alu_ovf),
        .alu_hilo_i    (alu_hilo),
        .alu_hilo_we_i (alu_hilo_we),
        .agu_addr_i    (agu_addr),
        .agu_dir_i     (agu_dir),
        .agu_size_i    (agu_size),
        .agu_signed_i  (agu_signed),
        .result_o      (result_o),
        .dest_o        (dest_o),
        .overflow_o    (overflow_o),
        .hilo_o        (hilo_o),
        .hilo_we_o     (hilo_we_o),
        .mem_addr_o    (mem_addr_o),
        .mem_dir_o     (mem_dir_o),
        .mem_size_o    (mem_size_o),
        .mem_signed_o  (mem_signed_o)
    );

endmodule

//--- sim/ex_clk_gen.sv
// free-running testbench clock, 4 ns period, starts low at time 0
`timescale 1ns/1ps

module ex_clk_gen
(
    output logic clk_o
);

    localparam int half_period = 2;

    initial
    begin
        clk_o = 1'b0;
        forever #half_period clk_o = ~clk_o;
    end

endmodule

//--- sim/ex_stage_tb.sv
// self-checking random test; load results and hi/lo values without a hi/lo write are not checked
`timescale 1ns/1ps

module ex_stage_tb;

    localparam int num_instr  = 2000;
    localparam int clk_period = 4;

    logic                       clk;
    logic                       rst_i;
    ex_isa_pkg::ex_op_e         op_i;
    logic [4:0]                 rs_i;
    logic [4:0]                 rt_i;
    logic [4:0]                 rd_i;
    logic [31:0]                rs_val_i;
    logic [31:0]                rt_val_i;
    logic [15:0]                imm_i;
    logic [4:0]                 shamt_i;
    logic [31:0]                return_addr_i;
    logic [63:0]                hilo_i;
    logic [31:0]                result_o;
    logic [4:0]                 dest_o;
    logic                       overflow_o;
    logic [63:0]                hilo_o;
    logic                       hilo_we_o;
    logic [31:0]                mem_addr_o;
    ex_mem_pkg::mem_dir_e       mem_dir_o;
    ex_mem_pkg::mem_size_e      mem_size_o;
    logic                       mem_signed_o;

    // model state for the instruction in flight
    ex_isa_pkg::ex_op_e         exp_op;
    logic [31:0]                exp_result;
    logic                       exp_res_chk;
    logic [4:0]                 exp_dest;
    logic                       exp_ovf;
    logic [63:0]                exp_hilo;
    logic                       exp_hilo_we;
    logic [31:0]                exp_addr;
    ex_mem_pkg::mem_dir_e       exp_dir;
    ex_mem_pkg::mem_size_e      exp_size;
    logic                       exp_signed;

    ex_isa_pkg::ex_op_e         op_table[$];
    integer                     seed;
    int                         checks;
    int                         errors;

    ex_clk_gen u_clk_gen
    (
        .clk_o (clk)
    );

    ex_stage dut
    (
        .clk           (clk),
        .rst_i         (rst_i),
        .op_i          (op_i),
        .rs_i          (rs_i),
        .rt_i          (rt_i),
        .rd_i          (rd_i),
        .rs_val_i      (rs_val_i),
        .rt_val_i      (rt_val_i),
        .imm_i         (imm_i),
        .shamt_i       (shamt_i),
        .return_addr_i (return_addr_i),
        .hilo_i        (hilo_i),
        .result_o      (result_o),
        .dest_o        (dest_o),
        .overflow_o    (overflow_o),
        .hilo_o        (hilo_o),
        .hilo_we_o     (hilo_we_o),
        .mem_addr_o    (mem_addr_o),
        .mem_dir_o     (mem_dir_o),
        .mem_size_o    (mem_size_o),
        .mem_signed_o  (mem_signed_o)
    );

    task automatic compare(input string what, input logic [63:0] got, input logic [63:0] expected);
        checks++;
        if (got !== expected)
        begin
            $display("CHECK FAILED at %0t: %s %s got %0h expected %0h",
                     $time, exp_op.name(), what, got, expected);
            errors++;
        end
    endtask

    // number of leading bits equal to bitval (32 when all match)
    function automatic logic [31:0] lead_count(input logic [31:0] v, input logic bitval);
        logic [31:0] n;
        logic        run;
        n   = '0;
        run = 1'b1;
        for (int i = 31; i >= 0; i--)
        begin
            if (run && (v[i] == bitval))
                n = n + 1;
            else
                run = 1'b0;
        end
        return n;
    endfunction

    // expected outputs for the inputs the DUT samples at this edge
    task automatic predict();
        logic [31:0] simm;
        logic [31:0] zimm;
        logic [32:0] wide;
        simm        = {{16{imm_i[15]}}, imm_i};
        zimm        = {16'h0000, imm_i};
        wide        = '0;
        exp_op      = op_i;
        exp_result  = '0;
        exp_res_chk = 1'b1;
        exp_hilo    = hilo_i;
        exp_hilo_we = 1'b0;
        case (op_i)
            ex_isa_pkg::op_add, ex_isa_pkg::op_addu:
            begin
                exp_result = rs_val_i + rt_val_i;
                wide       = {rs_val_i[31], rs_val_i} + {rt_val_i[31], rt_val_i};
            end
            ex_isa_pkg::op_sub, ex_isa_pkg::op_subu:
            begin
                exp_result = rs_val_i - rt_val_i;
                wide       = {rs_val_i[31], rs_val_i} - {rt_val_i[31], rt_val_i};
            end
            ex_isa_pkg::op_addi, ex_isa_pkg::op_addiu:
            begin
                exp_result = rs_val_i + simm;
                wide       = {rs_val_i[31], rs_val_i} + {simm[31], simm};
            end
            ex_isa_pkg::op_slt:   exp_result = {31'b0, $signed(rs_val_i) < $signed(rt_val_i)};
            ex_isa_pkg::op_sltu:  exp_result = {31'b0, rs_val_i < rt_val_i};
            ex_isa_pkg::op_slti:  exp_result = {31'b0, $signed(rs_val_i) < $signed(simm)};
            ex_isa_pkg::op_sltiu: exp_result = {31'b0, rs_val_i < simm};
            ex_isa_pkg::op_and:   exp_result = rs_val_i & rt_val_i;
            ex_isa_pkg::op_andi:  exp_result = rs_val_i & zimm;
            ex_isa_pkg::op_or:    exp_result = rs_val_i | rt_val_i;
            ex_isa_pkg::op_ori:   exp_result = rs_val_i | zimm;
            ex_isa_pkg::op_xor:   exp_result = rs_val_i ^ rt_val_i;
            ex_isa_pkg::op_xori:  exp_result = rs_val_i ^ zimm;
            ex_isa_pkg::op_nor:   exp_result = ~(rs_val_i | rt_val_i);
            ex_isa_pkg::op_lui:   exp_result = {imm_i, 16'h0000};
            ex_isa_pkg::op_sll:   exp_result = rt_val_i << shamt_i;
            ex_isa_pkg::op_sllv:  exp_result = rt_val_i << rs_val_i[4:0];
            ex_isa_pkg::op_srl:   exp_result = rt_val_i >> shamt_i;
            ex_isa_pkg::op_srlv:  exp_result = rt_val_i >> rs_val_i[4:0];
            ex_isa_pkg::op_sra:   exp_result = $signed(rt_val_i) >>> shamt_i;
            ex_isa_pkg::op_srav:  exp_result = $signed(rt_val_i) >>> rs_val_i[4:0];
            ex_isa_pkg::op_clz:   exp_result = lead_count(rs_val_i, 1'b0);
            ex_isa_pkg::op_clo:   exp_result = lead_count(rs_val_i, 1'b1);
            ex_isa_pkg::op_movz, ex_isa_pkg::op_movn:
                exp_result = rs_val_i;
            ex_isa_pkg::op_mfhi:  exp_result = hilo_i[63:32];
            ex_isa_pkg::op_mflo:  exp_result = hilo_i[31:0];
            ex_isa_pkg::op_jal, ex_isa_pkg::op_jalr:
                exp_result = return_addr_i;
            ex_isa_pkg::op_sb, ex_isa_pkg::op_sh, ex_isa_pkg::op_sw,
            ex_isa_pkg::op_swl, ex_isa_pkg::op_swr:
                exp_result = rt_val_i;
            default:
                exp_res_chk = 1'b0;
        endcase
        // only the trapping forms report the sign overflow
        exp_ovf = (op_i inside {ex_isa_pkg::op_add, ex_isa_pkg::op_sub, ex_isa_pkg::op_addi})
                  && (wide[32] != wide[31]);
        if (op_i == ex_isa_pkg::op_mthi)
        begin
            exp_hilo    = {rs_val_i, hilo_i[31:0]};
            exp_hilo_we = 1'b1;
        end
        if (op_i == ex_isa_pkg::op_mtlo)
        begin
            exp_hilo    = {hilo_i[63:32], rs_val_i};
            exp_hilo_we = 1'b1;
        end
        if (op_i inside {ex_isa_pkg::op_addi, ex_isa_pkg::op_addiu, ex_isa_pkg::op_slti,
                         ex_isa_pkg::op_sltiu, ex_isa_pkg::op_andi, ex_isa_pkg::op_ori,
                         ex_isa_pkg::op_xori, ex_isa_pkg::op_lui, ex_isa_pkg::op_lb,
                         ex_isa_pkg::op_lbu, ex_isa_pkg::op_lh, ex_isa_pkg::op_lhu,
                         ex_isa_pkg::op_lw, ex_isa_pkg::op_lwl, ex_isa_pkg::op_lwr})
            exp_dest = rt_i;
        else if (op_i == ex_isa_pkg::op_jal)
            exp_dest = 5'd31;
        else if (op_i == ex_isa_pkg::op_movz)
            exp_dest = (rt_val_i == 32'h0) ? rd_i : 5'd0;
        else if (op_i == ex_isa_pkg::op_movn)
            exp_dest = (rt_val_i != 32'h0) ? rd_i : 5'd0;
        else if (op_i inside {ex_isa_pkg::op_nop, ex_isa_pkg::op_mthi, ex_isa_pkg::op_mtlo,
                              ex_isa_pkg::op_sb, ex_isa_pkg::op_sh, ex_isa_pkg::op_sw,
                              ex_isa_pkg::op_swl, ex_isa_pkg::op_swr})
            exp_dest = 5'd0;
        else
            exp_dest = rd_i;
        if (exp_ovf)
        begin
            exp_dest    = 5'd0;
            exp_hilo_we = 1'b0;
        end
        // memory descriptor
        exp_dir    = ex_mem_pkg::dir_r2r;
        exp_size   = ex_mem_pkg::size_word;
        exp_signed = !(op_i inside {ex_isa_pkg::op_lbu, ex_isa_pkg::op_lhu});
        if (op_i inside {ex_isa_pkg::op_lb, ex_isa_pkg::op_lbu, ex_isa_pkg::op_lh,
                         ex_isa_pkg::op_lhu, ex_isa_pkg::op_lw, ex_isa_pkg::op_lwl,
                         ex_isa_pkg::op_lwr})
            exp_dir = ex_mem_pkg::dir_m2r;
        if (op_i inside {ex_isa_pkg::op_sb, ex_isa_pkg::op_sh, ex_isa_pkg::op_sw,
                         ex_isa_pkg::op_swl, ex_isa_pkg::op_swr})
            exp_dir = ex_mem_pkg::dir_r2m;
        if (op_i inside {ex_isa_pkg::op_lb, ex_isa_pkg::op_lbu, ex_isa_pkg::op_sb})
            exp_size = ex_mem_pkg::size_byte;
        if (op_i inside {ex_isa_pkg::op_lh, ex_isa_pkg::op_lhu, ex_isa_pkg::op_sh})
            exp_size = ex_mem_pkg::size_half;
        if (op_i inside {ex_isa_pkg::op_lwl, ex_isa_pkg::op_swl})
            exp_size = ex_mem_pkg::size_left_word;
        if (op_i inside {ex_isa_pkg::op_lwr, ex_isa_pkg::op_swr})
            exp_size = ex_mem_pkg::size_right_word;
        exp_addr = (exp_dir == ex_mem_pkg::dir_r2r) ? 32'h0 : rs_val_i + simm;
    endtask

    task automatic check_outputs();
        if (exp_res_chk)
            compare("result", 64'(result_o), 64'(exp_result));
        compare("dest", 64'(dest_o), 64'(exp_dest));
        compare("overflow", 64'(overflow_o), 64'(exp_ovf));
        compare("hilo_we", 64'(hilo_we_o), 64'(exp_hilo_we));
        if (exp_hilo_we)
            compare("hilo", hilo_o, exp_hilo);
        compare("mem_addr", 64'(mem_addr_o), 64'(exp_addr));
        compare("mem_dir", 64'(mem_dir_o), 64'(exp_dir));
        compare("mem_size", 64'(mem_size_o), 64'(exp_size));
        compare("mem_signed", 64'(mem_signed_o), 64'(exp_signed));
    endtask

    task automatic check_idle();
        exp_op = ex_isa_pkg::op_nop;
        compare("idle result", 64'(result_o), 64'h0);
        compare("idle dest", 64'(dest_o), 64'h0);
        compare("idle overflow", 64'(overflow_o), 64'h0);
        compare("idle hilo_we", 64'(hilo_we_o), 64'h0);
        compare("idle mem_addr", 64'(mem_addr_o), 64'h0);
        compare("idle mem_dir", 64'(mem_dir_o), 64'(ex_mem_pkg::dir_r2r));
        compare("idle mem_size", 64'(mem_size_o), 64'(ex_mem_pkg::size_word));
        compare("idle mem_signed", 64'(mem_signed_o), 64'h1);
    endtask

    // every eighth instruction has rt_val zero
    // two slots in 32 force clz of zero and clo of all ones to reach a count of 32
    task automatic drive_random(input int idx);
        logic [31:0]        r_op;
        logic [31:0]        r_fld;
        logic [31:0]        r_rs;
        logic [31:0]        r_rt;
        ex_isa_pkg::ex_op_e pick;
        r_op  = $random(seed);
        r_fld = $random(seed);
        r_rs  = $random(seed);
        r_rt  = $random(seed);
        pick  = op_table[r_op % op_table.size()];
        if (idx % 8 == 7)
            r_rt = 32'h0;
        if (idx % 32 == 13)
        begin
            pick = ex_isa_pkg::op_clz;
            r_rs = 32'h0;
        end
        if (idx % 32 == 29)
        begin
            pick = ex_isa_pkg::op_clo;
            r_rs = 32'hffff_ffff;
        end
        op_i          <= pick;
        rs_i          <= r_fld[4:0];
        rt_i          <= r_fld[9:5];
        rd_i          <= r_fld[14:10];
        shamt_i       <= r_fld[19:15];
        imm_i         <= r_op[31:16];
        rs_val_i      <= r_rs;
        rt_val_i      <= r_rt;
        return_addr_i <= $random(seed);
        hilo_i        <= {$random(seed), $random(seed)};
    endtask

    initial
    begin
        ex_isa_pkg::ex_op_e op;
        seed   = 32'h7713_907d;
        checks = 0;
        errors = 0;
        op     = op.first();
        for (int i = 0; i < op.num(); i++)
        begin
            op_table.push_back(op);
            op = op.next();
        end
        rst_i         = 1'b1;
        op_i          = ex_isa_pkg::op_nop;
        rs_i          = '0;
        rt_i          = '0;
        rd_i          = '0;
        rs_val_i      = '0;
        rt_val_i      = '0;
        imm_i         = '0;
        shamt_i       = '0;
        return_addr_i = '0;
        hilo_i        = '0;
        exp_op        = ex_isa_pkg::op_nop;
        for (int c = 0; c < 2; c++)
        begin
            @(posedge clk);
            if (c == 1)
                rst_i <= 1'b0;
            @(negedge clk);
            check_idle();
        end
        // first edge out of reset still samples a nop
        @(posedge clk);
        drive_random(0);
        @(negedge clk);
        check_idle();
        for (int i = 0; i < num_instr; i++)
        begin
            @(posedge clk);
            predict();
            if (i + 1 < num_instr)
                drive_random(i + 1);
            else
                op_i <= ex_isa_pkg::op_nop;
            @(negedge clk);
            check_outputs();
        end
        $display("checks %0d errors %0d", checks, errors);
        if (errors == 0)
            $display("TEST RESULT: PASS");
        else
            $display("TEST RESULT: FAIL");
        $finish;
    end

    // run length plus a margin of 20 cycles
    initial
    begin
        #((num_instr + 20) * clk_period);
        $display("timeout: the run did not finish within %0d clock cycles", num_instr + 20);
        $display("TEST RESULT: FAIL");
        $finish;
    end

endmodule

//--- sources.f
src/ex_isa_pkg.sv
src/ex_mem_pkg.sv
src/ex_alu.sv
src/ex_agu.sv
src/ex_writeback.sv
src/ex_stage.sv
sim/ex_clk_gen.sv
sim/ex_stage_tb.sv

//--- run_sim.sh
#!/usr/bin/env bash
# build and run the execute stage testbench with Verilator

set -u

cd "$(dirname "$0")" || exit 1

build_dir=obj_dir
sim_bin=ex_stage_sim
log_file=sim.log

if ! verilator --binary --timing -f sources.f --top-module ex_stage_tb \
    -Mdir "$build_dir" -o "$sim_bin"; then
    echo "build failed"
    exit 1
fi

"./$build_dir/$sim_bin" > "$log_file" 2>&1
run_status=$?
cat "$log_file"

if [ "$run_status" -ne 0 ]; then
    echo "simulation exited with status $run_status"
    exit 1
fi

if grep -q "TEST RESULT: PASS" "$log_file"; then
    echo "simulation passed"
    exit 0
else
    echo "simulation failed, see $log_file"
    exit 1
fi
